// ==== compile.f ====
design/stq_pkg.sv
design/stq_req_if.sv
design/stq_entries.sv
design/stq_age_matrix.sv
design/stq_pipe_picker.sv
design/store_queue.sv
verif/stq_checker.sv
verif/tb_store_queue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_store_queue
RTL_TOP   ?= store_queue
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -F -q '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_store_queue;

    localparam int          STQ_ENTRIES    = 8;
    localparam int          ROB_ID_W       = 6;
    localparam int          ID_W           = $clog2(STQ_ENTRIES);
    localparam int          NUM_CYCLES     = 3000;
    localparam int          TIMEOUT_CYCLES = NUM_CYCLES + 50;
    localparam int          PIPE_LAT       = 5;  // Grant to mm5 result.
    localparam int unsigned SEED           = 32'h6ac7528e;
    localparam logic [6:0]  OPC_LOAD       = 7'b0000011;

    logic                       clk;
    logic                       arst_n;
    logic                       nuke_valid;
    logic [ROB_ID_W-1:0]        nuke_robid;
    logic [ROB_ID_W-1:0]        oldest_robid;
    logic                       disp_valid;
    logic [stq_pkg::OPC_W-1:0]  disp_opcode;
    logic [ROB_ID_W-1:0]        disp_robid;
    logic [stq_pkg::SIZE_W-1:0] disp_size;
    logic [ID_W-1:0]            stq_id;
    logic                       iss_valid;
    logic [stq_pkg::OPC_W-1:0]  iss_opcode;
    logic [ID_W-1:0]            iss_stq_id;
    logic [stq_pkg::ADDR_W-1:0] iss_addr;
    logic [stq_pkg::DATA_W-1:0] iss_data;
    logic                       pipe_req;
    logic [ID_W-1:0]            pipe_stq_id;
    logic [stq_pkg::ADDR_W-1:0] pipe_addr;
    logic [stq_pkg::DATA_W-1:0] pipe_data;
    logic [stq_pkg::SIZE_W-1:0] pipe_size;
    logic                       pipe_gnt;
    logic                       res_valid;
    logic [ID_W-1:0]            res_stq_id;
    stq_pkg::t_stq_action       res_action;
    logic                       idle;
    logic                       full;
    logic [STQ_ENTRIES-1:0]     e_valid;
    int                         check_count;
    int                         error_count;

    int                         pend_id  [$];  // Memory pipe stand-in.
    int                         pend_due [$];
    stq_pkg::t_stq_action       pend_act [$];
    logic [STQ_ENTRIES-1:0]     issued;
    logic [ROB_ID_W-1:0]        next_robid;
    int                         cycle_cnt;

    store_queue #(.STQ_ENTRIES(STQ_ENTRIES), .ROB_ID_W(ROB_ID_W)) i_dut (.*);

    stq_checker #(.STQ_ENTRIES(STQ_ENTRIES), .ROB_ID_W(ROB_ID_W)) i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ####################
    // Stimulus
    // ####################

    task automatic clear_inputs();
        {nuke_valid, disp_valid, iss_valid, pipe_gnt, res_valid} = '0;
        nuke_robid   = '0;
        disp_opcode  = '0;
        disp_robid   = '0;
        disp_size    = '0;
        iss_opcode   = '0;
        iss_stq_id   = '0;
        iss_addr     = '0;
        iss_data     = '0;
        res_stq_id   = '0;
        res_action   = stq_pkg::ACT_NONE;
    endtask

    task automatic drive_result(input int k);
        res_valid  = 1'b0;
        res_stq_id = '0;
        res_action = stq_pkg::ACT_NONE;
        if (pend_due.size() > 0 && pend_due[0] == k) begin
            res_valid  = 1'b1;
            res_stq_id = ID_W'(pend_id.pop_front());
            res_action = pend_act.pop_front();
            void'(pend_due.pop_front());
        end
    endtask

    // Only with the pipe empty, so no result is left for a killed entry.
    task automatic drive_nuke();
        logic [ROB_ID_W-1:0] span;
        span       = next_robid - oldest_robid;
        nuke_valid = (pend_id.size() == 0) && !idle && ($urandom % 40 == 0);
        nuke_robid = oldest_robid + ROB_ID_W'($urandom % (32'(span) + 1));
        if (nuke_valid) next_robid = nuke_robid; // Younger ids reused.
        if (idle) oldest_robid = next_robid;
    endtask

    task automatic drive_dispatch();
        logic [ROB_ID_W-1:0] span;
        span        = next_robid - oldest_robid;
        disp_valid  = !nuke_valid && ($urandom % 2 == 0) && (span < ROB_ID_W'(48));
        disp_opcode = ($urandom % 5 == 0) ? OPC_LOAD : stq_pkg::OPC_STORE;
        disp_robid  = next_robid;
        disp_size   = stq_pkg::SIZE_W'($urandom);
        if (disp_valid) begin
            next_robid = next_robid + ROB_ID_W'(1 + $urandom % 2);
            if (disp_opcode == stq_pkg::OPC_STORE && !full) issued[stq_id] = 1'b0;
        end
    endtask

    task automatic drive_issue();
        logic [STQ_ENTRIES-1:0] cand;
        int                     start;
        int                     pick;
        cand  = e_valid & ~issued;
        pick  = -1;
        start = int'($urandom % STQ_ENTRIES);
        for (int i = 0; i < STQ_ENTRIES; i++) begin
            if (pick < 0 && cand[(start + i) % STQ_ENTRIES]) pick = (start + i) % STQ_ENTRIES;
        end
        iss_valid  = (pick >= 0) && ($urandom % 2 == 0);
        iss_opcode = ($urandom % 8 == 0) ? OPC_LOAD : stq_pkg::OPC_STORE;
        iss_stq_id = ID_W'((pick < 0) ? 0 : pick);
        iss_addr   = $urandom;
        iss_data   = $urandom;
        if (iss_valid && iss_opcode == stq_pkg::OPC_STORE) issued[pick] = 1'b1;
    endtask

    task automatic drive_grant(input int k);
        pipe_gnt = !nuke_valid && ($urandom % 10 < 6);
        if (pipe_gnt && pipe_req) begin
            pend_id.push_back(int'(pipe_stq_id));
            pend_due.push_back(k + PIPE_LAT);
            pend_act.push_back(($urandom % 10 < 7) ? stq_pkg::ACT_COMPLETE : stq_pkg::ACT_REPLAY);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n       = 1'b0;
        oldest_robid = '0;
        next_robid   = '0;
        issued       = '0;
        clear_inputs();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int k = 0; k < NUM_CYCLES; k++) begin
            @(negedge clk);
            drive_result(k);
            drive_nuke();
            drive_dispatch();
            drive_issue();
            drive_grant(k);
        end
        @(negedge clk);
        clear_inputs();
        repeat (4) @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/stq_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_checker #(
    parameter int STQ_ENTRIES = 8,
    parameter int ROB_ID_W    = 6
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            nuke_valid,
    input  logic [ROB_ID_W-1:0]             nuke_robid,
    input  logic [ROB_ID_W-1:0]             oldest_robid,
    input  logic                            disp_valid,
    input  logic [stq_pkg::OPC_W-1:0]       disp_opcode,
    input  logic [ROB_ID_W-1:0]             disp_robid,
    input  logic [stq_pkg::SIZE_W-1:0]      disp_size,
    input  logic [$clog2(STQ_ENTRIES)-1:0]  stq_id,
    input  logic                            iss_valid,
    input  logic [stq_pkg::OPC_W-1:0]       iss_opcode,
    input  logic [$clog2(STQ_ENTRIES)-1:0]  iss_stq_id,
    input  logic [stq_pkg::ADDR_W-1:0]      iss_addr,
    input  logic [stq_pkg::DATA_W-1:0]      iss_data,
    input  logic                            pipe_req,
    input  logic [$clog2(STQ_ENTRIES)-1:0]  pipe_stq_id,
    input  logic [stq_pkg::ADDR_W-1:0]      pipe_addr,
    input  logic [stq_pkg::DATA_W-1:0]      pipe_data,
    input  logic [stq_pkg::SIZE_W-1:0]      pipe_size,
    input  logic                            pipe_gnt,
    input  logic                            res_valid,
    input  logic [$clog2(STQ_ENTRIES)-1:0]  res_stq_id,
    input  stq_pkg::t_stq_action            res_action,
    input  logic                            idle,
    input  logic                            full,
    input  logic [STQ_ENTRIES-1:0]          e_valid,
    output int                              check_count,
    output int                              error_count
);

    localparam int ID_W = $clog2(STQ_ENTRIES);

    logic [STQ_ENTRIES-1:0]     sh_valid;
    logic [STQ_ENTRIES-1:0]     sh_ready;
    logic [STQ_ENTRIES-1:0]     sh_in_pipe;
    logic [ROB_ID_W-1:0]        sh_robid [STQ_ENTRIES];
    logic [stq_pkg::SIZE_W-1:0] sh_size  [STQ_ENTRIES];
    logic [stq_pkg::ADDR_W-1:0] sh_addr  [STQ_ENTRIES];
    logic [stq_pkg::DATA_W-1:0] sh_data  [STQ_ENTRIES];
    int                         sh_seq   [STQ_ENTRIES]; // Dispatch order.
    int                         next_seq;
    string                      last_event;
    logic                       held;                   // Request without grant last cycle.

    // Oldest ready entry not in the pipe, -1 if none.
    function automatic int oldest_ready();
        int best;
        best = -1;
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (sh_valid[e] && sh_ready[e] && !sh_in_pipe[e]) begin
                if (best < 0 || sh_seq[e] < sh_seq[best]) best = e;
            end
        end
        return best;
    endfunction

    function automatic int lowest_free();
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (!sh_valid[e]) return e;
        end
        return -1;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("Error: test %s, %s expected %0h, actual %0h at %0t",
                     test, what, exp, act, $time);
        end
    endtask

    // ####################
    // Compare
    // ####################

    task automatic compare_outputs();
        int    exp_id;
        int    free_id;
        string tname;
        exp_id  = oldest_ready();
        free_id = lowest_free();
        tname   = held ? "backpressure" : "order";
        check_value(last_event, "e_valid", 64'(sh_valid), 64'(e_valid));
        check_value(last_event, "idle", 64'(~|sh_valid), 64'(idle));
        check_value(last_event, "full", 64'(&sh_valid), 64'(full));
        if (free_id >= 0) check_value("alloc", "stq_id", 64'(free_id), 64'(stq_id));
        check_value(tname, "pipe_req", 64'(exp_id >= 0), 64'(pipe_req));
        if (exp_id >= 0 && pipe_req) begin
            check_value(tname, "pipe_stq_id", 64'(exp_id), 64'(pipe_stq_id));
            check_value(tname, "pipe_addr", 64'(sh_addr[exp_id]), 64'(pipe_addr));
            check_value(tname, "pipe_data", 64'(sh_data[exp_id]), 64'(pipe_data));
            check_value(tname, "pipe_size", 64'(sh_size[exp_id]), 64'(pipe_size));
        end
    endtask

    // ####################
    // Shadow update
    // ####################

    task automatic update_shadow();
        int                  win;
        int                  slot;
        logic [ROB_ID_W-1:0] nuke_age;
        logic [ROB_ID_W-1:0] age;
        logic                kill;
        win      = oldest_ready();
        slot     = -1;
        nuke_age = nuke_robid - oldest_robid;
        held     = (win >= 0) && !pipe_gnt;
        last_event = nuke_valid ? "nuke" : (res_valid ? "result" : "alloc");
        if (disp_valid && disp_opcode == stq_pkg::OPC_STORE && !(&sh_valid)) slot = lowest_free();
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            age  = sh_robid[e] - oldest_robid;
            kill = nuke_valid && sh_valid[e] && (age >= nuke_age);
            if (kill) begin
                sh_valid[e]   = 1'b0;
                sh_ready[e]   = 1'b0;
                sh_in_pipe[e] = 1'b0;
            end else if (e == slot) begin
                sh_valid[e]   = 1'b1;
                sh_ready[e]   = 1'b0;
                sh_in_pipe[e] = 1'b0;
                sh_robid[e]   = disp_robid;
                sh_size[e]    = disp_size;
                sh_seq[e]     = next_seq;
                next_seq      = next_seq + 1;
            end else if (sh_valid[e]) begin
                if (iss_valid && iss_opcode == stq_pkg::OPC_STORE && iss_stq_id == ID_W'(e)) begin
                    sh_ready[e] = 1'b1;
                    sh_addr[e]  = iss_addr;
                    sh_data[e]  = iss_data;
                end
                if (pipe_gnt && e == win) sh_in_pipe[e] = 1'b1;
                if (res_valid && res_stq_id == ID_W'(e)) begin
                    if (res_action == stq_pkg::ACT_COMPLETE) begin
                        sh_valid[e]   = 1'b0;
                        sh_ready[e]   = 1'b0;
                        sh_in_pipe[e] = 1'b0;
                    end else if (res_action == stq_pkg::ACT_REPLAY) begin
                        sh_in_pipe[e] = 1'b0;
                    end
                end
            end
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sh_valid   = '0;
            sh_ready   = '0;
            sh_in_pipe = '0;
            next_seq   = 0;
            held       = 1'b0;
            last_event = "reset"; // First compare after release.
            for (int e = 0; e < STQ_ENTRIES; e++) begin
                sh_robid[e] = '0;
                sh_seq[e]   = 0;
            end
        end else begin
            compare_outputs();
            update_shadow();
        end
    end

    initial begin
        check_count = 0;
        error_count = 0;
    end

endmodule

`default_nettype wire

// ==== design/store_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_queue #(
    parameter int STQ_ENTRIES = 8,
    parameter int ROB_ID_W    = 6
) (
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic                            nuke_valid,
    input  logic [ROB_ID_W-1:0]             nuke_robid,
    input  logic [ROB_ID_W-1:0]             oldest_robid,

    input  logic                            disp_valid,
    input  logic [stq_pkg::OPC_W-1:0]       disp_opcode,
    input  logic [ROB_ID_W-1:0]             disp_robid,
    input  logic [stq_pkg::SIZE_W-1:0]      disp_size,
    output logic [$clog2(STQ_ENTRIES)-1:0]  stq_id,

    input  logic                            iss_valid,
    input  logic [stq_pkg::OPC_W-1:0]       iss_opcode,
    input  logic [$clog2(STQ_ENTRIES)-1:0]  iss_stq_id,
    input  logic [stq_pkg::ADDR_W-1:0]      iss_addr,
    input  logic [stq_pkg::DATA_W-1:0]      iss_data,

    output logic                            pipe_req,
    output logic [$clog2(STQ_ENTRIES)-1:0]  pipe_stq_id,
    output logic [stq_pkg::ADDR_W-1:0]      pipe_addr,
    output logic [stq_pkg::DATA_W-1:0]      pipe_data,
    output logic [stq_pkg::SIZE_W-1:0]      pipe_size,
    input  logic                            pipe_gnt,

    input  logic                            res_valid,
    input  logic [$clog2(STQ_ENTRIES)-1:0]  res_stq_id,
    input  stq_pkg::t_stq_action            res_action,

    output logic                            idle,
    output logic                            full,
    output logic [STQ_ENTRIES-1:0]          e_valid
);

    logic [STQ_ENTRIES-1:0] alloc;
    logic [STQ_ENTRIES-1:0] elders [STQ_ENTRIES];

    stq_req_if #(.STQ_ENTRIES(STQ_ENTRIES)) req_if ();

    stq_entries #(
        .STQ_ENTRIES (STQ_ENTRIES),
        .ROB_ID_W    (ROB_ID_W)
    ) i_entries (
        .clk, .arst_n,
        .disp_valid, .disp_opcode, .disp_robid, .disp_size, .stq_id, .alloc,
        .iss_valid, .iss_opcode, .iss_stq_id, .iss_addr, .iss_data,
        .nuke_valid, .nuke_robid, .oldest_robid,
        .res_valid, .res_stq_id, .res_action,
        .e_valid, .idle, .full,
        .req_if (req_if.entries)
    );

    stq_age_matrix #(.STQ_ENTRIES(STQ_ENTRIES)) i_age_matrix (
        .clk, .arst_n, .alloc, .e_valid, .elders
    );

    stq_pipe_picker #(.STQ_ENTRIES(STQ_ENTRIES)) i_pipe_picker (
        .req_if (req_if.picker),
        .elders, .pipe_gnt,
        .pipe_req, .pipe_stq_id, .pipe_addr, .pipe_data, .pipe_size
    );

endmodule

`default_nettype wire

// ==== design/stq_pipe_picker.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_pipe_picker #(
    parameter int STQ_ENTRIES = 8
) (
    stq_req_if.picker                       req_if,
    input  logic [STQ_ENTRIES-1:0]          elders [STQ_ENTRIES],
    input  logic                            pipe_gnt,

    output logic                            pipe_req,
    output logic [$clog2(STQ_ENTRIES)-1:0]  pipe_stq_id,
    output logic [stq_pkg::ADDR_W-1:0]      pipe_addr,
    output logic [stq_pkg::DATA_W-1:0]      pipe_data,
    output logic [stq_pkg::SIZE_W-1:0]      pipe_size
);

    localparam int ID_W = $clog2(STQ_ENTRIES);

    logic [STQ_ENTRIES-1:0] win;

    // Oldest requester has no requesting elder.
    for (genvar e = 0; e < STQ_ENTRIES; e++) begin : g_win
        assign win[e] = req_if.req[e] && !(|(elders[e] & req_if.req));
    end

    assign pipe_req   = |req_if.req;
    assign req_if.gnt = pipe_gnt ? win : '0;

    // ####################
    // Payload mux
    // ####################

    always_comb begin
        pipe_stq_id = '0;
        pipe_addr   = '0;
        pipe_data   = '0;
        pipe_size   = '0;
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (win[e]) begin
                pipe_stq_id = ID_W'(e);
                pipe_addr   = req_if.addr[e];
                pipe_data   = req_if.data[e];
                pipe_size   = req_if.size[e];
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/stq_age_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_age_matrix #(
    parameter int STQ_ENTRIES = 8
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [STQ_ENTRIES-1:0]  alloc,   // One-hot or zero.
    input  logic [STQ_ENTRIES-1:0]  e_valid,
    output logic [STQ_ENTRIES-1:0]  elders [STQ_ENTRIES]
);

    // Row r, bit c set means entry c was dispatched before entry r.
    logic [STQ_ENTRIES-1:0] mtx [STQ_ENTRIES];

    // ####################
    // Matrix update
    // ####################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < STQ_ENTRIES; r++) begin
                mtx[r] <= '0;
            end
        end else begin
            for (int r = 0; r < STQ_ENTRIES; r++) begin
                if (alloc[r]) begin
                    // Everything valid now is older than the new store.
                    mtx[r] <= e_valid & ~alloc;
                end else begin
                    mtx[r] <= mtx[r] & ~alloc; // New entry is younger.
                end
            end
        end
    end

    // Stale bits of freed entries stay; the picker masks rows with requests.
    for (genvar r = 0; r < STQ_ENTRIES; r++) begin : g_rows
        assign elders[r] = mtx[r];
    end

endmodule

`default_nettype wire

// ==== design/stq_entries.sv ====
`timescale 1ns/1ps
`default_nettype none

module stq_entries #(
    parameter int STQ_ENTRIES = 8,
    parameter int ROB_ID_W    = 6
) (
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic                            disp_valid,
    input  logic [stq_pkg::OPC_W-1:0]       disp_opcode,
    input  logic [ROB_ID_W-1:0]             disp_robid,
    input  logic [stq_pkg::SIZE_W-1:0]      disp_size,
    output logic [$clog2(STQ_ENTRIES)-1:0]  stq_id,
    output logic [STQ_ENTRIES-1:0]          alloc,

    input  logic                            iss_valid,
    input  logic [stq_pkg::OPC_W-1:0]       iss_opcode,
    input  logic [$clog2(STQ_ENTRIES)-1:0]  iss_stq_id,
    input  logic [stq_pkg::ADDR_W-1:0]      iss_addr,
    input  logic [stq_pkg::DATA_W-1:0]      iss_data,

    input  logic                            nuke_valid,
    input  logic [ROB_ID_W-1:0]             nuke_robid,
    input  logic [ROB_ID_W-1:0]             oldest_robid,

    input  logic                            res_valid,
    input  logic [$clog2(STQ_ENTRIES)-1:0]  res_stq_id,
    input  stq_pkg::t_stq_action            res_action,

    output logic [STQ_ENTRIES-1:0]          e_valid,
    output logic                            idle,
    output logic                            full,

    stq_req_if.entries                      req_if
);

    localparam int ID_W = $clog2(STQ_ENTRIES);

    logic [STQ_ENTRIES-1:0]         e_ready;   // Address and data captured.
    logic [STQ_ENTRIES-1:0]         e_in_pipe;
    logic [ROB_ID_W-1:0]            e_robid [STQ_ENTRIES];
    logic [stq_pkg::SIZE_W-1:0]     e_size  [STQ_ENTRIES];
    logic [stq_pkg::ADDR_W-1:0]     e_addr  [STQ_ENTRIES];
    logic [stq_pkg::DATA_W-1:0]     e_data  [STQ_ENTRIES];

    logic [STQ_ENTRIES-1:0]         alloc_sel;
    logic [ID_W-1:0]                alloc_idx;
    logic                           disp_ok;
    logic                           iss_ok;
    logic [ROB_ID_W-1:0]            nuke_age;
    logic [ROB_ID_W-1:0]            e_age   [STQ_ENTRIES];
    logic [STQ_ENTRIES-1:0]         kill;
    logic [STQ_ENTRIES-1:0]         iss_hit;
    logic [STQ_ENTRIES-1:0]         res_hit;

    // ####################
    // Allocation
    // ####################

    // Walk downwards so the lowest free entry is the last one written.
    always_comb begin
        alloc_sel = '0;
        alloc_idx = '0;
        for (int i = STQ_ENTRIES - 1; i >= 0; i--) begin
            if (!e_valid[i]) begin
                alloc_sel    = '0;
                alloc_sel[i] = 1'b1;
                alloc_idx    = ID_W'(i);
            end
        end
    end

    assign disp_ok = disp_valid && (disp_opcode == stq_pkg::OPC_STORE) && !full;
    assign alloc   = disp_ok ? alloc_sel : '0;
    assign stq_id  = alloc_idx;

    assign idle = ~|e_valid;
    assign full = &e_valid;

    // ####################
    // Entry decode
    // ####################

    assign iss_ok   = iss_valid && (iss_opcode == stq_pkg::OPC_STORE);
    assign nuke_age = nuke_robid - oldest_robid; // Distance from oldest in flight.

    always_comb begin
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            e_age[e]   = e_robid[e] - oldest_robid;
            kill[e]    = nuke_valid && e_valid[e] && (e_age[e] >= nuke_age);
            iss_hit[e] = iss_ok && e_valid[e] && (iss_stq_id == ID_W'(e));
            res_hit[e] = res_valid && e_valid[e] && (res_stq_id == ID_W'(e));
        end
    end

    // ####################
    // Entry state
    // ####################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            e_valid   <= '0;
            e_ready   <= '0;
            e_in_pipe <= '0;
        end else begin
            for (int e = 0; e < STQ_ENTRIES; e++) begin
                if (kill[e]) begin // Nuke wins.
                    e_valid[e]   <= 1'b0;
                    e_ready[e]   <= 1'b0;
                    e_in_pipe[e] <= 1'b0;
                end else if (alloc[e]) begin
                    e_valid[e]   <= 1'b1;
                    e_ready[e]   <= 1'b0;
                    e_in_pipe[e] <= 1'b0;
                end else begin
                    if (iss_hit[e]) e_ready[e] <= 1'b1;
                    if (req_if.gnt[e]) e_in_pipe[e] <= 1'b1;
                    if (res_hit[e] && res_action == stq_pkg::ACT_COMPLETE) begin
                        e_valid[e]   <= 1'b0;
                        e_ready[e]   <= 1'b0;
                        e_in_pipe[e] <= 1'b0;
                    end else if (res_hit[e] && res_action == stq_pkg::ACT_REPLAY) begin
                        e_in_pipe[e] <= 1'b0; // Ready again.
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int e = 0; e < STQ_ENTRIES; e++) begin
            if (alloc[e]) begin
                e_robid[e] <= disp_robid;
                e_size[e]  <= disp_size;
            end
            if (iss_hit[e] && !kill[e]) begin
                e_addr[e] <= iss_addr;
                e_data[e] <= iss_data;
            end
        end
    end

    // Requests toward the picker.
    assign req_if.req = e_valid & e_ready & ~e_in_pipe;

    for (genvar e = 0; e < STQ_ENTRIES; e++) begin : g_payload
        assign req_if.addr[e] = e_addr[e];
        assign req_if.data[e] = e_data[e];
        assign req_if.size[e] = e_size[e];
    end

endmodule

`default_nettype wire

// ==== design/stq_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Per-entry pipe requests from the entry array to the picker.
interface stq_req_if #(
    parameter int STQ_ENTRIES = 8
);

    logic [STQ_ENTRIES-1:0]          req;
    logic [STQ_ENTRIES-1:0]          gnt;  // One-hot.
    logic [stq_pkg::ADDR_W-1:0]      addr [STQ_ENTRIES];
    logic [stq_pkg::DATA_W-1:0]      data [STQ_ENTRIES];
    logic [stq_pkg::SIZE_W-1:0]      size [STQ_ENTRIES];

    modport entries (output req, output addr, output data, output size, input gnt);

    modport picker (input req, input addr, input data, input size, output gnt);

endinterface

`default_nettype wire

// ==== design/stq_pkg.sv ====
`default_nettype none

package stq_pkg;

    // ####################
    // Widths
    // ####################

    localparam int ADDR_W = 32; // Store address.
    localparam int DATA_W = 32; // Store data.
    localparam int OPC_W  = 7;  // Major opcode field.
    localparam int SIZE_W = 2;  // Byte, half, word, double.

    // ####################
    // Opcodes
    // ####################

    // RISC-V STORE major opcode.
    localparam logic [OPC_W-1:0] OPC_STORE = 7'b0100011;

    // ####################
    // Pipe result
    // ####################

    // Action returned by the memory pipe at mm5.
    typedef enum logic [1:0] {
        ACT_NONE     = 2'd0, // No change to the entry.
        ACT_COMPLETE = 2'd1, // Store done, entry is freed.
        ACT_REPLAY   = 2'd2  // Send the store again later.
    } t_stq_action;

endpackage

`default_nettype wire
